// File: hw/sifh_defines.svh
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// timestamp width in bits
`define SIFH_NP 10

// upper timestamp bits that pick the bin
`define SIFH_BIN_BITS 5

// bins per histogram
`define SIFH_BIN_NUM (1 << `SIFH_BIN_BITS)

// bin counter width, saturates at all ones
`define SIFH_CNT_W 8

// acquisitions per pixel
`define SIFH_ACQ_NUM 4

// timestamps per acquisition
`define SIFH_DATA_NUM 8

// pixels per frame
`define SIFH_PIXEL_NUM 3

// pixel index width
`define SIFH_PIX_W 2

`endif

// File: hw/sifhPkg.sv
`default_nettype none

package sifhPkg;

    `include "sifh_defines.svh"

    // raw timestamp as it arrives
    typedef logic [`SIFH_NP-1:0] stamp_t;

    // bin index, top bits of a stamp
    typedef logic [`SIFH_BIN_BITS-1:0] bin_t;

    // per-bin hit counter
    typedef logic [`SIFH_CNT_W-1:0] count_t;

    // pixel position within a frame
    typedef logic [`SIFH_PIX_W-1:0] pixel_t;

    // builder: filling a bank, or stalled with both banks taken
    typedef enum logic {
        FILL,
        WAIT_BANK
    } builderState_e;

    // peak finder: scan, then four-phase result handshake
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        REQ,
        ACK_WAIT
    } peakState_e;

endpackage

`default_nettype wire

// File: hw/sampleFramer.sv
`timescale 1ns/1ns
`default_nettype none
`include "sifh_defines.svh"

module sampleFramer
    import sifhPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic accept,
    output logic      sampleLast,
    output pixel_t    pixel
);

    // counter widths from the frame shape
    localparam int DATA_W = $clog2(`SIFH_DATA_NUM);
    localparam int ACQ_W  = $clog2(`SIFH_ACQ_NUM);

    // sample within acquisition
    logic [DATA_W-1:0] dataCnt;
    // acquisition within pixel
    logic [ACQ_W-1:0]  acqCnt;

    logic lastData;
    logic lastAcq;
    logic lastPixel;

    // end-of-range decodes
    assign lastData  = (dataCnt == DATA_W'(`SIFH_DATA_NUM - 1));
    assign lastAcq   = (acqCnt == ACQ_W'(`SIFH_ACQ_NUM - 1));
    assign lastPixel = (pixel == pixel_t'(`SIFH_PIXEL_NUM - 1));

    // current sample closes its pixel
    assign sampleLast = lastData && lastAcq;

    always_ff @(posedge clk) begin
        if (rst) begin
            dataCnt <= '0;
            acqCnt  <= '0;
            pixel   <= '0;
        end else if (accept) begin
            // innermost counter steps on every accepted sample
            if (lastData) begin
                dataCnt <= '0;
            end else begin
                dataCnt <= dataCnt + 1'b1;
            end

            // acquisition steps when its samples are done
            if (lastData) begin
                if (lastAcq) begin
                    acqCnt <= '0;
                end else begin
                    acqCnt <= acqCnt + 1'b1;
                end
            end

            // pixel steps at end of pixel, wraps at frame end
            if (lastData && lastAcq) begin
                if (lastPixel) begin
                    pixel <= '0;
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/histMem.sv
`timescale 1ns/1ns
`default_nettype none
`include "sifh_defines.svh"

module histMem
    import sifhPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   updEn,
    input  wire logic   updBank,
    input  wire bin_t   updBin,
    input  wire count_t updCount,
    input  wire logic   rdBank,
    input  wire bin_t   rdBin,
    output count_t      rdCount,
    input  wire logic   scanBank,
    input  wire bin_t   scanBin,
    input  wire logic   scanClr,
    output count_t      scanCount
);

    // post-reset sweep that zeroes both banks
    logic clrActive;
    bin_t clrIdx;

    // unregistered bank outputs, muxed below
    count_t bankRd   [2];
    count_t bankScan [2];

    always_ff @(posedge clk) begin
        if (rst) begin
            clrActive <= 1'b1;
            clrIdx    <= '0;
        end else if (clrActive) begin
            clrIdx <= clrIdx + 1'b1;
            if (clrIdx == bin_t'(`SIFH_BIN_NUM - 1)) begin
                clrActive <= 1'b0;
            end
        end
    end

    for (genvar b = 0; b < 2; b++) begin : gBank
        count_t cells [`SIFH_BIN_NUM];
        logic   zeroWr;
        logic   updWr;
        bin_t   zeroIdx;

        // scan port only ever writes zero
        assign zeroWr  = clrActive || (scanClr && (scanBank == 1'(b)));
        assign updWr   = updEn && (updBank == 1'(b));
        assign zeroIdx = clrActive ? clrIdx : scanBin;

        // builder and scanner never own the same bank
        always_ff @(posedge clk) begin
            if (zeroWr) begin
                cells[zeroIdx] <= '0;
            end else if (updWr) begin
                cells[updBin] <= updCount;
            end
        end

        assign bankRd[b]   = cells[rdBin];
        assign bankScan[b] = cells[scanBin];
    end

    // registered reads, old value on a same-cycle write
    always_ff @(posedge clk) begin
        rdCount   <= bankRd[rdBank];
        scanCount <= bankScan[scanBank];
    end

endmodule

`default_nettype wire

// File: hw/histBuilderFsm.sv
`timescale 1ns/1ns
`default_nettype none
`include "sifh_defines.svh"

module histBuilderFsm
    import sifhPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   wrEn,
    input  wire stamp_t data,
    output logic        ready,
    input  wire logic   sampleLast,
    input  wire pixel_t pixel,
    output logic        updEn,
    output logic        updBank,
    output bin_t        updBin,
    output count_t      updCount,
    output logic        rdBank,
    output bin_t        rdBin,
    input  wire count_t rdCount,
    output logic        bankFull,
    output logic        fullBank,
    output pixel_t      fullPixel,
    input  wire logic   bankFree
);

    builderState_e state;

    // bank being filled, and whether the scanner holds the other one
    logic fillBank;
    logic scanBusy;

    // mirrors the memory clear sweep after reset
    bin_t initCnt;
    logic initDone;

    logic   accept;
    logic   pixEnd;
    logic   hand;
    pixel_t lastPixel;

    // stage 1, read issued
    logic s1Valid;
    logic s1Bank;
    bin_t s1Bin;

    // write seen last cycle, not yet visible in rdCount
    logic   wrValid;
    logic   wrBank;
    bin_t   wrBin;
    count_t wrCount;
    count_t baseCount;

    // handoff delay so the last write lands before the scan
    logic   handV;
    logic   handBank;
    pixel_t handPixel;

    assign ready  = initDone && (state == FILL);
    assign accept = wrEn && ready;
    assign pixEnd = accept && sampleLast;

    // pass the filled bank on when the scanner is free
    assign hand = ((state == FILL) && pixEnd && (!scanBusy || bankFree))
               || ((state == WAIT_BANK) && bankFree);

    // bin is the top stamp bits
    assign rdBin  = data[`SIFH_NP-1 -: `SIFH_BIN_BITS];
    assign rdBank = fillBank;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FILL;
            fillBank <= 1'b0;
            scanBusy <= 1'b0;
            initCnt  <= '0;
            initDone <= 1'b0;
        end else begin
            if (!initDone) begin
                initCnt <= initCnt + 1'b1;
                if (initCnt == bin_t'(`SIFH_BIN_NUM - 1)) begin
                    initDone <= 1'b1;
                end
            end
            case (state)
                FILL: begin
                    // pixel done but other bank still scanning
                    if (pixEnd && !hand) begin
                        state <= WAIT_BANK;
                    end
                end
                WAIT_BANK: begin
                    if (bankFree) begin
                        state <= FILL;
                    end
                end
                default: state <= FILL;
            endcase
            if (hand) begin
                fillBank <= !fillBank;
                scanBusy <= 1'b1;
            end else if (bankFree) begin
                scanBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid  <= 1'b0;
            wrValid  <= 1'b0;
            handV    <= 1'b0;
            bankFull <= 1'b0;
        end else begin
            s1Valid  <= accept;
            wrValid  <= updEn;
            handV    <= hand;
            bankFull <= handV;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin     <= rdBin;
        s1Bank    <= fillBank;
        wrBin     <= updBin;
        wrBank    <= updBank;
        wrCount   <= updCount;
        if (pixEnd) begin
            lastPixel <= pixel;
        end
        handBank  <= fillBank;
        // framer has moved on once stalled
        handPixel <= (state == FILL) ? pixel : lastPixel;
        fullBank  <= handBank;
        fullPixel <= handPixel;
    end

    // stage 2, forward the previous write on a bin match
    always_comb begin
        if (wrValid && (wrBin == s1Bin) && (wrBank == s1Bank)) begin
            baseCount = wrCount;
        end else begin
            baseCount = rdCount;
        end
        // saturating increment
        if (baseCount == '1) begin
            updCount = baseCount;
        end else begin
            updCount = baseCount + 1'b1;
        end
    end

    assign updEn   = s1Valid;
    assign updBin  = s1Bin;
    assign updBank = s1Bank;

endmodule

`default_nettype wire

// File: hw/peakFinder.sv
`timescale 1ns/1ns
`default_nettype none
`include "sifh_defines.svh"

module peakFinder
    import sifhPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   bankFull,
    input  wire logic   fullBank,
    input  wire pixel_t fullPixel,
    output logic        scanBank,
    output bin_t        scanBin,
    output logic        scanClr,
    input  wire count_t scanCount,
    output logic        resReq,
    input  wire logic   resAck,
    output pixel_t      resPixel,
    output bin_t       resBin,
    output count_t      resCount,
    output logic        bankFree
);

    peakState_e state;

    // read address walking up through the bins
    bin_t binIdx;

    // bank and pixel owned for this scan
    logic   curBank;
    pixel_t curPixel;

    // compare stage, one cycle behind the read
    logic cmpValid;
    bin_t cmpBin;

    // running maximum
    bin_t   bestBin;
    count_t bestCount;

    assign scanBank = curBank;
    assign scanBin  = binIdx;
    // clear each bin in the same cycle it is read
    assign scanClr  = (state == SCAN);

    assign resPixel = curPixel;
    assign resBin   = bestBin;
    assign resCount = bestCount;

    // bank clean and handshake closed
    assign bankFree = (state == ACK_WAIT) && !resAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            binIdx   <= '0;
            resReq   <= 1'b0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= (state == SCAN);
            case (state)
                IDLE: begin
                    if (bankFull) begin
                        binIdx <= '0;
                        state  <= SCAN;
                    end
                end
                SCAN: begin
                    binIdx <= binIdx + 1'b1;
                    if (binIdx == bin_t'(`SIFH_BIN_NUM - 1)) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // first cycle here drains the compare stage
                    if (!resReq && !resAck) begin
                        resReq <= 1'b1;
                    end else if (resReq && resAck) begin
                        resReq <= 1'b0;
                        state  <= ACK_WAIT;
                    end
                end
                ACK_WAIT: begin
                    if (!resAck) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= binIdx;
        if ((state == IDLE) && bankFull) begin
            curBank   <= fullBank;
            curPixel  <= fullPixel;
            bestBin   <= '0;
            bestCount <= '0;
        end else if (cmpValid && (scanCount > bestCount)) begin
            // strictly larger only, lowest bin wins a tie
            bestBin   <= cmpBin;
            bestCount <= scanCount;
        end
    end

endmodule

`default_nettype wire

// File: hw/sifhTop.sv
`timescale 1ns/1ns
`default_nettype none

module sifhTop
    import sifhPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   wrEn,
    input  wire stamp_t data,
    output logic        ready,
    output logic        resReq,
    input  wire logic   resAck,
    output pixel_t      resPixel,
    output bin_t        resBin,
    output count_t      resCount
);

    // framer to builder
    logic   accept;
    logic   sampleLast;
    pixel_t pixel;

    // builder to memory update port
    logic   updEn;
    logic   updBank;
    bin_t   updBin;
    count_t updCount;
    logic   rdBank;
    bin_t   rdBin;
    count_t rdCount;

    // bank handoff between builder and peak finder
    logic   bankFull;
    logic   fullBank;
    pixel_t fullPixel;
    logic   bankFree;

    // peak finder to memory scan port
    logic   scanBank;
    bin_t   scanBin;
    logic   scanClr;
    count_t scanCount;

    // framer advances only on accepted samples
    assign accept = wrEn && ready;

    sampleFramer sampleFramer_inst (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .sampleLast (sampleLast),
        .pixel      (pixel)
    );

    histBuilderFsm histBuilderFsm_inst (
        .clk        (clk),
        .rst        (rst),
        .wrEn       (wrEn),
        .data       (data),
        .ready      (ready),
        .sampleLast (sampleLast),
        .pixel      (pixel),
        .updEn      (updEn),
        .updBank    (updBank),
        .updBin     (updBin),
        .updCount   (updCount),
        .rdBank     (rdBank),
        .rdBin      (rdBin),
        .rdCount    (rdCount),
        .bankFull   (bankFull),
        .fullBank   (fullBank),
        .fullPixel  (fullPixel),
        .bankFree   (bankFree)
    );

    histMem histMem_inst (
        .clk       (clk),
        .rst       (rst),
        .updEn     (updEn),
        .updBank   (updBank),
        .updBin    (updBin),
        .updCount  (updCount),
        .rdBank    (rdBank),
        .rdBin     (rdBin),
        .rdCount   (rdCount),
        .scanBank  (scanBank),
        .scanBin   (scanBin),
        .scanClr   (scanClr),
        .scanCount (scanCount)
    );

    peakFinder peakFinder_inst (
        .clk       (clk),
        .rst       (rst),
        .bankFull  (bankFull),
        .fullBank  (fullBank),
        .fullPixel (fullPixel),
        .scanBank  (scanBank),
        .scanBin   (scanBin),
        .scanClr   (scanClr),
        .scanCount (scanCount),
        .resReq    (resReq),
        .resAck    (resAck),
        .resPixel  (resPixel),
        .resBin    (resBin),
        .resCount  (resCount),
        .bankFree  (bankFree)
    );

endmodule

`default_nettype wire

// File: test/sifh_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module sifhAsserts
    import sifhPkg::*;
(
    input wire logic   clk,
    input wire logic   rst,
    input wire logic   ready,
    input wire logic   resReq,
    input wire logic   resAck,
    input wire pixel_t resPixel,
    input wire bin_t   resBin,
    input wire count_t resCount
);

    int failCnt = 0;

    // request held until acknowledged
    reqHold: assert property (@(posedge clk) disable iff (rst)
        resReq && !resAck |=> resReq)
    else begin
        $error("resReq dropped before resAck");
        failCnt++;
    end

    // result fields frozen while requested
    dataStable: assert property (@(posedge clk) disable iff (rst)
        resReq && $past(resReq) |-> $stable({resPixel, resBin, resCount}))
    else begin
        $error("result data changed while resReq was high");
        failCnt++;
    end

    // new request only after the old ack is gone
    reqAfterAck: assert property (@(posedge clk) disable iff (rst)
        $rose(resReq) |-> !$past(resAck))
    else begin
        $error("resReq rose while resAck was high");
        failCnt++;
    end

    // 32-cycle memory clear, then ready
    readyAfterClear: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> ##32 ready)
    else begin
        $error("ready not high after the reset clear");
        failCnt++;
    end

endmodule

bind sifhTop sifhAsserts sifhAsserts_inst (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .resReq   (resReq),
    .resAck   (resAck),
    .resPixel (resPixel),
    .resBin   (resBin),
    .resCount (resCount)
);

`default_nettype wire

// File: test/sifhTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "sifh_defines.svh"

module sifhTb
    import sifhPkg::*;
;

    localparam int SAMPLES_PER_PIXEL = `SIFH_ACQ_NUM * `SIFH_DATA_NUM;
    localparam int BIN_NUM = 1 << `SIFH_BIN_BITS;
    localparam int CNT_MAX = (1 << `SIFH_CNT_W) - 1;
    localparam int LOW_W = `SIFH_NP - `SIFH_BIN_BITS;
    // pixels over all six tests
    localparam int TOTAL_PIXELS = 24;
    localparam int LIMIT_CYCLES = 4 * TOTAL_PIXELS * SAMPLES_PER_PIXEL + 200 * TOTAL_PIXELS;

    logic   clk = 1'b0;
    logic   rst;
    logic   wrEn;
    stamp_t data;
    logic   ready;
    logic   resReq;
    logic   resAck;
    pixel_t resPixel;
    bin_t   resBin;
    count_t resCount;

    int errCount = 0;
    int resultCnt = 0;
    int testCnt = 0;
    int ackMin = 0;
    int ackMax = 5;
    logic readyLowSeen = 1'b0;

    // stamps waiting to be driven
    stamp_t stimQ [$];

    // reference histogram of the pixel being filled
    int     hist [BIN_NUM];
    int     sampleCnt = 0;
    pixel_t modelPixel = '0;

    // expected results in arrival order
    pixel_t expPix [$];
    bin_t   expBin [$];
    count_t expCnt [$];

    sifhTop sifhTop_inst (
        .clk      (clk),
        .rst      (rst),
        .wrEn     (wrEn),
        .data     (data),
        .ready    (ready),
        .resReq   (resReq),
        .resAck   (resAck),
        .resPixel (resPixel),
        .resBin   (resBin),
        .resCount (resCount)
    );

    always #2 clk = ~clk;

    // everything in the testbench moves 1 ns after the edge
    task automatic waitCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkPixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkBin(input string name, input bin_t got, input bin_t exp);
        if (got !== exp) begin
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkCount(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
            errCount++;
        end
    endtask

    function automatic void clearHist();
        for (int i = 0; i < BIN_NUM; i++) begin
            hist[i] = 0;
        end
    endfunction

    // lowest bin with the highest count wins
    function automatic void closePixel();
        int best;
        best = 0;
        for (int i = 1; i < BIN_NUM; i++) begin
            if (hist[i] > hist[best]) begin
                best = i;
            end
        end
        expPix.push_back(modelPixel);
        expBin.push_back(bin_t'(best));
        expCnt.push_back(count_t'(hist[best]));
        clearHist();
        sampleCnt = 0;
        modelPixel = (modelPixel == pixel_t'(`SIFH_PIXEL_NUM - 1)) ? '0 : modelPixel + 1'b1;
    endfunction

    function automatic void modelAccept(input stamp_t s);
        int b;
        b = int'(s) >> LOW_W;
        // counters stop at all ones
        if (hist[b] < CNT_MAX) begin
            hist[b]++;
        end
        sampleCnt++;
        if (sampleCnt == SAMPLES_PER_PIXEL) begin
            closePixel();
        end
    endfunction

    function automatic stamp_t makeStamp(input int b);
        return stamp_t'((b << LOW_W) | ($urandom % (1 << LOW_W)));
    endfunction

    function automatic void genRandom(input int pixels, input int binSpan);
        for (int i = 0; i < pixels * SAMPLES_PER_PIXEL; i++) begin
            stimQ.push_back(makeStamp($urandom % binSpan));
        end
    endfunction

    // back-to-back repeats of one stamp, runs of 1 to 8
    function automatic void genRuns(input int pixels);
        int left;
        int len;
        stamp_t s;
        for (int p = 0; p < pixels; p++) begin
            left = SAMPLES_PER_PIXEL;
            while (left > 0) begin
                len = 1 + $urandom % 8;
                if (len > left) begin
                    len = left;
                end
                s = makeStamp($urandom % BIN_NUM);
                for (int k = 0; k < len; k++) begin
                    stimQ.push_back(s);
                end
                left -= len;
            end
        end
    endfunction

    // one bin all pixel long, then two and four way ties
    function automatic void genTies();
        for (int i = 0; i < SAMPLES_PER_PIXEL; i++) begin
            stimQ.push_back(makeStamp(19));
        end
        for (int i = 0; i < SAMPLES_PER_PIXEL; i++) begin
            stimQ.push_back(makeStamp((i % 2 == 0) ? 22 : 9));
        end
        for (int i = 0; i < SAMPLES_PER_PIXEL; i++) begin
            case (i % 4)
                0: stimQ.push_back(makeStamp(30));
                1: stimQ.push_back(makeStamp(12));
                2: stimQ.push_back(makeStamp(5));
                default: stimQ.push_back(makeStamp(27));
            endcase
        end
    endfunction

    // ready is stable for the whole cycle, so accept is known here
    task automatic driveQueue(input int gapMax);
        stamp_t s;
        int gap;
        while (stimQ.size() > 0) begin
            s = stimQ.pop_front();
            gap = (gapMax > 0) ? $urandom % (gapMax + 1) : 0;
            repeat (gap) begin
                wrEn = 1'b0;
                data = stamp_t'($urandom);
                waitCycle();
            end
            wrEn = 1'b1;
            data = s;
            while (!ready) begin
                readyLowSeen = 1'b1;
                waitCycle();
            end
            modelAccept(s);
            waitCycle();
        end
        wrEn = 1'b0;
    endtask

    task automatic checkResult();
        if (expPix.size() == 0) begin
            $display("result for pixel 0x%0h arrived with no expected result", resPixel);
            errCount++;
        end else begin
            checkPixel("resPixel", resPixel, expPix.pop_front());
            checkBin("resBin", resBin, expBin.pop_front());
            checkCount("resCount", resCount, expCnt.pop_front());
        end
        resultCnt++;
    endtask

    task automatic runTest(input string name, input int gapMax, input bit expectStall);
        int errBefore;
        int target;
        errBefore = errCount;
        target = resultCnt + stimQ.size() / SAMPLES_PER_PIXEL;
        readyLowSeen = 1'b0;
        driveQueue(gapMax);
        // results trail the stimulus by a scan and a handshake
        while (resultCnt < target) begin
            waitCycle();
        end
        if (expectStall && !readyLowSeen) begin
            $display("ready never dropped while the responder was slow");
            errCount++;
        end
        testCnt++;
        $display("test %0d %s done, %0d errors", testCnt, name, errCount - errBefore);
    endtask

    // four-phase consumer
    initial begin : responder
        int delay;
        resAck = 1'b0;
        forever begin
            waitCycle();
            if (resReq) begin
                delay = ackMin + $urandom % (ackMax - ackMin + 1);
                repeat (delay) begin
                    waitCycle();
                end
                checkResult();
                resAck = 1'b1;
                while (resReq) begin
                    waitCycle();
                end
                resAck = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout, run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        void'($urandom(32'ha40e));
        rst = 1'b1;
        wrEn = 1'b0;
        data = '0;
        clearHist();
        repeat (4) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        // memory clear sweep
        while (!ready) begin
            waitCycle();
        end

        genRandom(6, BIN_NUM);
        runTest("random stamps over two frames", 0, 1'b0);
        genRuns(3);
        runTest("runs of identical stamps", 0, 1'b0);
        genTies();
        runTest("single bin and ties", 0, 1'b0);
        genRandom(3, BIN_NUM);
        runTest("random wrEn gaps", 3, 1'b0);
        ackMin = 30;
        ackMax = 40;
        genRandom(3, BIN_NUM);
        runTest("slow responder", 0, 1'b1);
        ackMin = 0;
        ackMax = 5;
        // few bins, so stale counts would move the peak
        genRandom(6, 4);
        runTest("bank reuse", 0, 1'b0);

        repeat (10) begin
            waitCycle();
        end
        if (expPix.size() != 0) begin
            $display("%0d expected results never arrived", expPix.size());
            errCount++;
        end
        if (sifhTop_inst.sifhAsserts_inst.failCnt != 0) begin
            $display("%0d assertion failures", sifhTop_inst.sifhAsserts_inst.failCnt);
            errCount += sifhTop_inst.sifhAsserts_inst.failCnt;
        end
        $display("tests %0d, results %0d, errors %0d", testCnt, resultCnt, errCount);
        if (errCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/sifhPkg.sv
hw/sampleFramer.sv
hw/histMem.sv
hw/histBuilderFsm.sv
hw/peakFinder.sv
hw/sifhTop.sv
test/sifh_asserts.sv
test/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - include_dirs:
      - hw
    files:
      - hw/sifhPkg.sv
      - hw/sampleFramer.sv
      - hw/histMem.sv
      - hw/histBuilderFsm.sv
      - hw/peakFinder.sv
      - hw/sifhTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/sifh_asserts.sv
      - test/sifhTb.sv
